// ==== Bender.yml ====
package:
  name: contra

sources:
  - src/contra_pkg.sv
  - src/cpu_bus_if.sv
  - src/cen_gen.sv
  - src/main_bus_decoder.sv
  - src/video_ram.sv
  - src/sound_latch.sv
  - src/video_control.sv
  - src/contra_game.sv
  - target: test
    files:
      - testbench/contra_game_tb.sv

// ==== contra.f ====
src/contra_pkg.sv
src/cpu_bus_if.sv
src/cen_gen.sv
src/main_bus_decoder.sv
src/video_ram.sv
src/sound_latch.sv
src/video_control.sv
src/contra_game.sv
testbench/contra_game_tb.sv

// ==== src/cen_gen.sv ====
// Clock enables for the 12, 3 and 1.5 MHz domains, derived from 24 MHz.
// All pulses are one clk wide and aligned on the same counter.
`timescale 1ns/10ps
`default_nettype none

module cen_gen (
    input  logic clk,
    input  logic reset,
    output logic cen12,
    output logic cen3,
    output logic cen1p5
);

    logic [3:0] cnt;

    // Pulses fire as the counter wraps its low bits, so a slower
    // enable always lands on a faster one
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt    <= 4'd0;
            cen12  <= 1'b0;
            cen3   <= 1'b0;
            cen1p5 <= 1'b0;
        end else begin
            cnt    <= cnt + 4'd1;
            cen12  <= cnt[0];
            cen3   <= &cnt[2:0];
            cen1p5 <= &cnt;
        end
    end

    // CPU slot must sit on a 12 MHz edge
    cen3_on_cen12: assert property (
        @(posedge clk) disable iff (reset)
        cen3 |-> cen12
    );

endmodule

`default_nettype wire

// ==== src/contra_game.sv ====
// Game top level, board glue only: clock enables, CPU bus decode,
// video RAMs, sound latch and video control, all on plain ports.
`timescale 1ns/10ps
`default_nettype none

module contra_game #(
    parameter int GFX_AW = 11,
    parameter int PAL_AW = 8
) (
    input  logic              clk,
    input  logic              reset,
    // Main CPU port
    input  logic              cpu_req,
    input  logic              cpu_rnw,
    input  contra_pkg::addr_t cpu_addr,
    input  contra_pkg::data_t cpu_dout,
    output logic              cpu_ack,
    output contra_pkg::data_t cpu_din,
    // Sound CPU side
    input  logic              snd_ack,
    output contra_pkg::data_t snd_latch,
    output logic              snd_irq,
    output logic              cen12,
    output logic              cen1p5,
    // Cabinet and debug
    input  logic [23:0]       dipsw,
    input  logic [1:0]        debug_sel,
    output logic              prio_latch,
    output contra_pkg::data_t debug_view
);
    import contra_pkg::*;

    logic  cen3;
    data_t gfx1_rd;
    data_t gfx2_rd;
    data_t pal_rd;
    data_t vctrl_rd;

    cpu_bus_if bus ();

    cen_gen u_cen (
        .clk    ( clk    ),
        .reset  ( reset  ),
        .cen12  ( cen12  ),
        .cen3   ( cen3   ),
        .cen1p5 ( cen1p5 )
    );

    // CPU bus slot runs on the 3 MHz enable
    main_bus_decoder #(
        .GFX_AW ( GFX_AW ),
        .PAL_AW ( PAL_AW )
    ) u_decoder (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .cpu_cen  ( cen3     ),
        .req      ( cpu_req  ),
        .rnw      ( cpu_rnw  ),
        .addr     ( cpu_addr ),
        .wdata    ( cpu_dout ),
        .ack      ( cpu_ack  ),
        .rdata    ( cpu_din  ),
        .bus      ( bus      ),
        .gfx1_rd  ( gfx1_rd  ),
        .gfx2_rd  ( gfx2_rd  ),
        .pal_rd   ( pal_rd   ),
        .vctrl_rd ( vctrl_rd )
    );

    video_ram #(.AW(GFX_AW)) u_gfx1 (
        .clk ( clk          ),
        .bus ( bus          ),
        .sel ( bus.gfx1_sel ),
        .rd  ( gfx1_rd      )
    );

    video_ram #(.AW(GFX_AW)) u_gfx2 (
        .clk ( clk          ),
        .bus ( bus          ),
        .sel ( bus.gfx2_sel ),
        .rd  ( gfx2_rd      )
    );

    video_ram #(.AW(PAL_AW)) u_pal (
        .clk ( clk         ),
        .bus ( bus         ),
        .sel ( bus.pal_sel ),
        .rd  ( pal_rd      )
    );

    sound_latch u_snd (
        .clk       ( clk       ),
        .reset     ( reset     ),
        .bus       ( bus       ),
        .snd_ack   ( snd_ack   ),
        .snd_latch ( snd_latch ),
        .snd_irq   ( snd_irq   )
    );

    // video_bank would feed the tile renderer, not present here
    video_control u_vctrl (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .bus        ( bus        ),
        .rd         ( vctrl_rd   ),
        .dipsw      ( dipsw      ),
        .debug_sel  ( debug_sel  ),
        .video_bank (            ),
        .prio_latch ( prio_latch ),
        .debug_view ( debug_view )
    );

endmodule

`default_nettype wire

// ==== src/contra_pkg.sv ====
// Shared types and memory map for the game glue logic.
// Imported by the bus interface, the decoder and every bus target.
`default_nettype none

package contra_pkg;

    localparam int ADDR_W = 16;
    localparam int DATA_W = 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // Destination of one main CPU access
    typedef enum logic [2:0] {
        tgt_none,
        tgt_gfx1,
        tgt_gfx2,
        tgt_pal,
        tgt_snd_latch,
        tgt_vctrl
    } target_e;

    // Region bases, matched on the bits above each region's width
    localparam addr_t GFX1_BASE = 16'h2000;
    localparam addr_t GFX2_BASE = 16'h4000;
    localparam addr_t PAL_BASE  = 16'h0C00;

    // Single-address registers
    localparam addr_t SND_LATCH_ADDR = 16'h0800;
    localparam addr_t VBANK_ADDR     = 16'h0700;
    localparam addr_t PRIO_ADDR      = 16'h0701;

    // Open bus value
    localparam data_t UNMAPPED_DATA = 8'hFF;

endpackage

`default_nettype wire

// ==== src/cpu_bus_if.sv ====
// One main CPU access, from the bus decoder out to the RAMs and registers.
// The decoder drives it all; read data comes back on separate ports.
`timescale 1ns/10ps
`default_nettype none

interface cpu_bus_if;
    import contra_pkg::*;

    addr_t addr;
    data_t wdata;
    logic  we;

    // One strobe per target, high for the single access cycle
    logic  gfx1_sel;
    logic  gfx2_sel;
    logic  pal_sel;
    logic  snd_sel;
    logic  vctrl_sel;

    modport master (
        output addr, wdata, we,
        output gfx1_sel, gfx2_sel, pal_sel, snd_sel, vctrl_sel
    );

    modport target (
        input addr, wdata, we,
        input gfx1_sel, gfx2_sel, pal_sel, snd_sel, vctrl_sel
    );

endinterface

`default_nettype wire

// ==== src/main_bus_decoder.sv ====
// Main CPU port with a four-phase req/ack handshake.
// Each request waits for the next CPU bus slot, strobes one target and
// returns its read data, or the open bus value outside the map.
`timescale 1ns/10ps
`default_nettype none

module main_bus_decoder #(
    parameter int GFX_AW = 11,
    parameter int PAL_AW = 8
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              cpu_cen,
    input  logic              req,
    input  logic              rnw,
    input  contra_pkg::addr_t addr,
    input  contra_pkg::data_t wdata,
    output logic              ack,
    output contra_pkg::data_t rdata,
    cpu_bus_if.master         bus,
    input  contra_pkg::data_t gfx1_rd,
    input  contra_pkg::data_t gfx2_rd,
    input  contra_pkg::data_t pal_rd,
    input  contra_pkg::data_t vctrl_rd
);
    import contra_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_wait_slot,
        st_access,
        st_capture,
        st_done
    } state_e;

    state_e  state;
    target_e target;
    addr_t   addr_q;
    data_t   wdata_q;
    logic    rnw_q;

    function automatic target_e classify(input addr_t a);
        target_e t;
        t = tgt_none;
        if ((a >> GFX_AW) == (GFX1_BASE >> GFX_AW))
            t = tgt_gfx1;
        else if ((a >> GFX_AW) == (GFX2_BASE >> GFX_AW))
            t = tgt_gfx2;
        else if ((a >> PAL_AW) == (PAL_BASE >> PAL_AW))
            t = tgt_pal;
        else if (a == SND_LATCH_ADDR)
            t = tgt_snd_latch;
        else if (a == VBANK_ADDR || a == PRIO_ADDR)
            t = tgt_vctrl;
        return t;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            ack   <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (req)
                        state <= st_wait_slot;
                end
                st_wait_slot: begin
                    if (cpu_cen)
                        state <= st_access;
                end
                st_access: begin
                    state <= st_capture;
                end
                st_capture: begin
                    state <= st_done;
                    ack   <= 1'b1;
                end
                st_done: begin
                    // ack and data hold while req stays high
                    if (!req) begin
                        state <= st_idle;
                        ack   <= 1'b0;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Request fields held for the whole transaction
    always_ff @(posedge clk) begin
        if (state == st_idle && req) begin
            addr_q  <= addr;
            wdata_q <= wdata;
            rnw_q   <= rnw;
            target  <= classify(addr);
        end
        if (state == st_capture) begin
            case (target)
                tgt_gfx1:  rdata <= gfx1_rd;
                tgt_gfx2:  rdata <= gfx2_rd;
                tgt_pal:   rdata <= pal_rd;
                tgt_vctrl: rdata <= vctrl_rd;
                // Sound latch is write-only
                default:   rdata <= UNMAPPED_DATA;
            endcase
        end
    end

    assign bus.addr  = addr_q;
    assign bus.wdata = wdata_q;
    assign bus.we    = ~rnw_q;

    assign bus.gfx1_sel  = (state == st_access) && (target == tgt_gfx1);
    assign bus.gfx2_sel  = (state == st_access) && (target == tgt_gfx2);
    assign bus.pal_sel   = (state == st_access) && (target == tgt_pal);
    assign bus.snd_sel   = (state == st_access) && (target == tgt_snd_latch);
    assign bus.vctrl_sel = (state == st_access) && (target == tgt_vctrl);

    sel_onehot: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0({bus.gfx1_sel, bus.gfx2_sel, bus.pal_sel, bus.snd_sel, bus.vctrl_sel})
    );

    ack_needs_req: assert property (
        @(posedge clk) disable iff (reset)
        $rose(ack) |-> req
    );

endmodule

`default_nettype wire

// ==== src/sound_latch.sv ====
// Command byte from the main CPU to the sound CPU.
// A write raises snd_irq until the sound side answers with snd_ack.
`timescale 1ns/10ps
`default_nettype none

module sound_latch (
    input  logic              clk,
    input  logic              reset,
    cpu_bus_if.target         bus,
    input  logic              snd_ack,
    output contra_pkg::data_t snd_latch,
    output logic              snd_irq
);
    import contra_pkg::*;

    logic latch_wr;

    assign latch_wr = bus.snd_sel && bus.we;

    always_ff @(posedge clk) begin
        if (reset) begin
            snd_latch <= '0;
            snd_irq   <= 1'b0;
        end else if (latch_wr) begin
            // A new command keeps the request pending
            snd_latch <= bus.wdata;
            snd_irq   <= 1'b1;
        end else if (snd_irq && snd_ack) begin
            snd_irq   <= 1'b0;
        end
    end

    irq_falls_after_ack: assert property (
        @(posedge clk) disable iff (reset)
        $fell(snd_irq) |-> $past(snd_ack)
    );

endmodule

`default_nettype wire

// ==== src/video_control.sv ====
// Video bank and priority registers, readable by the main CPU.
// Also picks the debug view byte from the bank or a DIP switch bank.
`timescale 1ns/10ps
`default_nettype none

module video_control (
    input  logic              clk,
    input  logic              reset,
    cpu_bus_if.target         bus,
    output contra_pkg::data_t rd,
    input  logic [23:0]       dipsw,
    input  logic [1:0]        debug_sel,
    output contra_pkg::data_t video_bank,
    output logic              prio_latch,
    output contra_pkg::data_t debug_view
);
    import contra_pkg::*;

    data_t      dipsw_a;
    data_t      dipsw_b;
    logic [3:0] dipsw_c;
    logic       is_prio;

    assign dipsw_a = dipsw[7:0];
    assign dipsw_b = dipsw[15:8];
    assign dipsw_c = dipsw[23:20];
    assign is_prio = (bus.addr == PRIO_ADDR);

    always_ff @(posedge clk) begin
        if (reset) begin
            video_bank <= '0;
            prio_latch <= 1'b0;
        end else if (bus.vctrl_sel && bus.we) begin
            if (is_prio)
                prio_latch <= bus.wdata[0];
            else
                video_bank <= bus.wdata;
        end
    end

    // Read back path, same latency as the RAMs
    always_ff @(posedge clk) begin
        if (bus.vctrl_sel)
            rd <= is_prio ? {7'd0, prio_latch} : video_bank;
    end

    always_ff @(posedge clk) begin
        case (debug_sel)
            2'd0: debug_view <= video_bank;
            2'd1: debug_view <= dipsw_a;
            2'd2: debug_view <= dipsw_b;
            default: debug_view <= {4'd0, dipsw_c};
        endcase
    end

endmodule

`default_nettype wire

// ==== src/video_ram.sv ====
// Single-port byte RAM on the CPU bus, shared code for gfx and palette.
// Reads are registered on every selected cycle, one cycle of latency.
`timescale 1ns/10ps
`default_nettype none

module video_ram #(
    parameter int AW = 11
) (
    input  logic              clk,
    cpu_bus_if.target         bus,
    input  logic              sel,
    output contra_pkg::data_t rd
);
    import contra_pkg::*;

    data_t mem [2**AW];

    logic [AW-1:0] waddr;

    // Low bits only, the decoder has already matched the region
    assign waddr = bus.addr[AW-1:0];

    always_ff @(posedge clk) begin
        if (sel) begin
            if (bus.we)
                mem[waddr] <= bus.wdata;
            rd <= mem[waddr];
        end
    end

endmodule

`default_nettype wire

// ==== testbench/contra_game_tb.sv ====
// Self-checking testbench for the game glue top level.
// Runs the operations of the pattern file against a reference model of the memory map.
`timescale 1ns/10ps
`default_nettype none

module contra_game_tb;
    import contra_pkg::*;

    localparam int GFX_AW     = 11;
    localparam int PAL_AW     = 8;
    localparam int PAT_MAX    = 256;
    localparam int CEN_WINDOW = 48;

    localparam logic [3:0] OP_WRITE = 4'h0;
    localparam logic [3:0] OP_READ  = 4'h1;
    localparam logic [3:0] OP_SOUND = 4'h2;
    localparam logic [3:0] OP_DEBUG = 4'h3;
    localparam logic [3:0] OP_DIPSW = 4'h4;
    localparam logic [3:0] OP_END   = 4'hf;

    logic        clk = 1'b0;
    logic        reset;
    logic        cpu_req;
    logic        cpu_rnw;
    addr_t       cpu_addr;
    data_t       cpu_dout;
    logic        cpu_ack;
    data_t       cpu_din;
    logic        snd_ack;
    data_t       snd_latch;
    logic        snd_irq;
    logic        cen12;
    logic        cen1p5;
    logic [23:0] dipsw;
    logic [1:0]  debug_sel;
    logic        prio_latch;
    data_t       debug_view;

    // Word layout is op, address or select, data or expected value
    logic [43:0] patterns [PAT_MAX];
    data_t       ref_mem [65536];
    data_t       vbank_model;
    logic        prio_model;
    logic [23:0] dipsw_model;
    int          num_patterns;
    int          cycle_count;
    int          cycle_limit;
    integer      seed;

    contra_game #(
        .GFX_AW ( GFX_AW ),
        .PAL_AW ( PAL_AW )
    ) contra_game_inst (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .cpu_req    ( cpu_req    ),
        .cpu_rnw    ( cpu_rnw    ),
        .cpu_addr   ( cpu_addr   ),
        .cpu_dout   ( cpu_dout   ),
        .cpu_ack    ( cpu_ack    ),
        .cpu_din    ( cpu_din    ),
        .snd_ack    ( snd_ack    ),
        .snd_latch  ( snd_latch  ),
        .snd_irq    ( snd_irq    ),
        .cen12      ( cen12      ),
        .cen1p5     ( cen1p5     ),
        .dipsw      ( dipsw      ),
        .debug_sel  ( debug_sel  ),
        .prio_latch ( prio_latch ),
        .debug_view ( debug_view )
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("TEST FAIL");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_byte(input string what, input data_t got, input data_t exp);
        assert (got === exp) else
            abort_run($sformatf("FAILED at %0t ns: %s is %02h, expected %02h",
                                $time, what, got, exp));
    endtask

    function automatic int rand_gap();
        return $unsigned($random(seed)) % 4;
    endfunction

    function automatic logic in_ram(input addr_t a);
        return ((a >> GFX_AW) == (GFX1_BASE >> GFX_AW))
            || ((a >> GFX_AW) == (GFX2_BASE >> GFX_AW))
            || ((a >> PAL_AW) == (PAL_BASE >> PAL_AW));
    endfunction

    function automatic data_t model_read(input addr_t a);
        if (in_ram(a))
            return ref_mem[a];
        if (a == VBANK_ADDR)
            return vbank_model;
        if (a == PRIO_ADDR)
            return {7'd0, prio_model};
        // Sound latch is write-only and the rest is open bus
        return UNMAPPED_DATA;
    endfunction

    function automatic data_t debug_model(input logic [1:0] sel);
        case (sel)
            2'd0: return vbank_model;
            2'd1: return dipsw_model[7:0];
            2'd2: return dipsw_model[15:8];
            default: return {4'd0, dipsw_model[23:20]};
        endcase
    endfunction

    // One four-phase transaction with random idle and back-pressure cycles
    task automatic cpu_access(input logic rnw, input addr_t a, input data_t wd,
                              output data_t rd);
        int    hold;
        data_t first;
        repeat (rand_gap()) @(posedge clk);
        @(posedge clk);
        cpu_req  <= 1'b1;
        cpu_rnw  <= rnw;
        cpu_addr <= a;
        cpu_dout <= wd;
        @(negedge clk);
        assert (cpu_ack === 1'b0) else abort_run("cpu_ack was already high when cpu_req rose");
        while (cpu_ack !== 1'b1)
            @(negedge clk);
        first = cpu_din;
        hold = rand_gap();
        repeat (hold) begin
            @(negedge clk);
            assert (cpu_ack === 1'b1) else abort_run("cpu_ack dropped while cpu_req was held");
            check_byte("held cpu_din", cpu_din, first);
        end
        @(posedge clk);
        cpu_req <= 1'b0;
        @(negedge clk);
        assert (cpu_ack === 1'b1) else abort_run("cpu_ack fell in the same cycle as cpu_req");
        @(negedge clk);
        assert (cpu_ack === 1'b0) else abort_run("cpu_ack did not fall after cpu_req fell");
        rd = first;
    endtask

    task automatic sound_handshake(input data_t exp);
        int gap;
        @(negedge clk);
        assert (snd_irq === 1'b1) else abort_run("snd_irq is not pending before the handshake");
        gap = rand_gap();
        repeat (gap) begin
            @(negedge clk);
            assert (snd_irq === 1'b1) else abort_run("snd_irq fell before snd_ack was raised");
        end
        @(posedge clk);
        snd_ack <= 1'b1;
        do @(negedge clk); while (snd_irq !== 1'b0);
        @(posedge clk);
        snd_ack <= 1'b0;
        @(negedge clk);
        assert (snd_irq === 1'b0) else abort_run("snd_irq rose again after the handshake");
        check_byte("snd_latch", snd_latch, exp);
    endtask

    task automatic debug_check(input logic [1:0] sel, input data_t exp);
        data_t model;
        model = debug_model(sel);
        assert (model === exp) else
            abort_run($sformatf("Pattern file expects %02h for debug_sel %0d, model gives %02h",
                                exp, sel, model));
        @(posedge clk);
        debug_sel <= sel;
        // Registered view lags the select by one cycle
        @(posedge clk);
        @(negedge clk);
        check_byte($sformatf("debug_view for select %0d", sel), debug_view, model);
    endtask

    task automatic check_enables();
        int   n12;
        int   n1p5;
        int   since_1p5;
        logic seen;
        n12 = 0;
        n1p5 = 0;
        since_1p5 = 0;
        seen = 1'b0;
        repeat (CEN_WINDOW) begin
            @(negedge clk);
            if (cen12) begin
                n12++;
                since_1p5++;
            end
            if (cen1p5) begin
                n1p5++;
                assert (cen12) else abort_run("cen1p5 pulsed without a cen12 pulse");
                if (seen) begin
                    assert (since_1p5 == 8) else
                        abort_run($sformatf("FAILED at %0t ns: %0d cen12 per cen1p5, expected 8",
                                            $time, since_1p5));
                end
                since_1p5 = 0;
                seen = 1'b1;
            end
        end
        assert (n12 == CEN_WINDOW / 2 && n1p5 == CEN_WINDOW / 16) else
            abort_run($sformatf("FAILED at %0t ns: %0d cen12 and %0d cen1p5 pulses in %0d cycles",
                                $time, n12, n1p5, CEN_WINDOW));
    endtask

    task automatic run_pattern(input logic [43:0] word);
        logic [3:0]  op;
        addr_t       a;
        logic [23:0] d;
        data_t       rd;
        data_t       exp;
        op = word[43:40];
        a = word[39:24];
        d = word[23:0];
        case (op)
            OP_WRITE: begin
                cpu_access(1'b0, a, d[7:0], rd);
                if (in_ram(a))
                    ref_mem[a] = d[7:0];
                else if (a == VBANK_ADDR)
                    vbank_model = d[7:0];
                else if (a == PRIO_ADDR)
                    prio_model = d[0];
                if (a == SND_LATCH_ADDR) begin
                    assert (snd_irq === 1'b1) else
                        abort_run("snd_irq not raised by a latch write");
                    check_byte("snd_latch", snd_latch, d[7:0]);
                end
                if (a == PRIO_ADDR)
                    check_byte("prio_latch", {7'd0, prio_latch}, {7'd0, prio_model});
            end
            OP_READ: begin
                exp = model_read(a);
                assert (exp === d[7:0]) else
                    abort_run($sformatf("Pattern file expects %02h at %04h, model gives %02h",
                                        d[7:0], a, exp));
                cpu_access(1'b1, a, 8'h00, rd);
                check_byte($sformatf("read of %04h", a), rd, exp);
            end
            OP_SOUND: sound_handshake(d[7:0]);
            OP_DEBUG: debug_check(a[1:0], d[7:0]);
            OP_DIPSW: begin
                @(posedge clk);
                dipsw <= d;
                dipsw_model = d;
            end
            default: abort_run($sformatf("Unknown operation %0h in the pattern file", op));
        endcase
    endtask

    initial begin
        int i;
        reset = 1'b1;
        cpu_req = 1'b0;
        cpu_rnw = 1'b1;
        cpu_addr = '0;
        cpu_dout = '0;
        snd_ack = 1'b0;
        dipsw = '0;
        debug_sel = '0;
        seed = 32'hed8a32e1;
        vbank_model = '0;
        prio_model = 1'b0;
        dipsw_model = '0;
        cycle_count = 0;
        for (i = 0; i < PAT_MAX; i++)
            patterns[i] = {OP_END, 40'd0};
        $readmemh("testbench/contra_patterns.txt", patterns);
        num_patterns = 0;
        while (num_patterns < PAT_MAX && patterns[num_patterns][43:40] != OP_END)
            num_patterns++;
        cycle_limit = 20 * num_patterns + 200;
        if (num_patterns == 0)
            abort_run("No operations were read from the pattern file");

        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (cpu_ack === 1'b0 && snd_irq === 1'b0 && prio_latch === 1'b0) else
            abort_run("cpu_ack, snd_irq or prio_latch is not low after reset");
        check_byte("snd_latch after reset", snd_latch, 8'h00);
        // First cycle with reset released
        @(negedge clk);
        assert (cen12 === 1'b0 && cen1p5 === 1'b0) else
            abort_run("Clock enables pulse in the first cycle after reset");
        check_enables();

        for (i = 0; i < num_patterns; i++)
            run_pattern(patterns[i]);

        @(posedge clk);
        $display("TEST PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/contra_patterns.txt ====
// Columns: op_address_data, op 0 write, 1 read-expect, 2 sound handshake (expected latch),
// 3 debug-expect (address is debug_sel), 4 set DIP switches (data is the 24-bit value)
0_2000_00005a
0_27ff_0000c3
0_4000_0000a5
0_47ff_00003c
0_0c00_000011
0_0cff_0000ee
1_2000_00005a
1_27ff_0000c3
1_4000_0000a5
1_47ff_00003c
1_0c00_000011
1_0cff_0000ee
1_8000_0000ff
1_0800_0000ff
0_0800_000042
0_0800_000099
2_0000_000099
0_0700_000037
0_0701_000001
1_0700_000037
1_0701_000001
4_0000_b5a17e
3_0000_000037
3_0001_00007e
3_0002_0000a1
3_0003_00000b
0_0701_000000
1_0701_000000
